/* src/board_pkg.sv */
`default_nettype none

package board_pkg;

    // number of push keys on the board
    localparam int n_keys = 3;

    // digits on the seven-segment display
    localparam int n_digits = 8;

    // a key level has to hold this long before it is accepted
    localparam int debounce_ms = 10;

    // the scanner steps to the next digit at this rate
    localparam int scan_hz = 1000;

    // the dot marks the boundary between minutes and seconds
    localparam int dot_index = 5;

    // one decimal digit
    typedef logic [3:0] bcd_digit_t;

    // four decimal digits, most significant digit in the top nibble
    typedef logic [15:0] bcd4_t;

    typedef logic [n_keys - 1:0] key_vec_t;

    // segments a b c d e f g h from msb to lsb, a lit segment is 1
    typedef logic [7:0] seg_t;

    // bit i enables digit i, digit 0 is the leftmost one
    typedef logic [n_digits - 1:0] digit_sel_t;

    typedef logic [3:0] led_vec_t;

    // segment pattern and digit select, updated together
    typedef struct packed {
        seg_t       seg;
        digit_sel_t sel;
    } disp_out_t;

endpackage

`default_nettype wire

/* src/second_tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module second_tick_gen #(
    parameter int clk_hz = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic second_tick
);

    localparam int cnt_w = (clk_hz > 1) ? $clog2(clk_hz) : 1;

    logic [cnt_w - 1:0] cnt;

    // the strobe is registered, so it lasts exactly one clk cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            second_tick <= 1'b0;
        end else begin
            if (cnt == cnt_w'(clk_hz - 1)) begin
                cnt         <= '0;
                second_tick <= 1'b1;
            end else begin
                cnt         <= cnt + 1'b1;
                second_tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/key_press_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module key_press_counter #(
    parameter int clk_hz = 50_000_000
) (
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::key_vec_t key,
    output board_pkg::key_vec_t key_level,
    output board_pkg::bcd4_t    key_count
);

    import board_pkg::*;

    localparam int deb_raw = clk_hz * debounce_ms / 1000;
    localparam int deb_len = (deb_raw < 2) ? 2 : deb_raw;
    localparam int deb_w   = $clog2(deb_len);

    key_vec_t         sync_1;
    key_vec_t         sync_2;
    key_vec_t         level;
    key_vec_t         level_d;
    key_vec_t         press;
    logic [deb_w-1:0] stab_cnt [n_keys];

    // add one to a four-digit decimal value, 9999 rolls over to 0000
    function automatic bcd4_t bcd_inc(input bcd4_t v);
        bcd4_t      r;
        bcd_digit_t d;
        logic       carry;
        r     = v;
        carry = 1'b1;
        for (int i = 0; i < 4; i++) begin
            d = r[i*4 +: 4];
            if (carry) begin
                if (d == 4'd9) begin
                    d = 4'd0;
                end else begin
                    d     = d + 4'd1;
                    carry = 1'b0;
                end
            end
            r[i*4 +: 4] = d;
        end
        return r;
    endfunction

    // subtract one, 0000 borrows all the way round to 9999
    function automatic bcd4_t bcd_dec(input bcd4_t v);
        bcd4_t      r;
        bcd_digit_t d;
        logic       borrow;
        r      = v;
        borrow = 1'b1;
        for (int i = 0; i < 4; i++) begin
            d = r[i*4 +: 4];
            if (borrow) begin
                if (d == 4'd0) begin
                    d = 4'd9;
                end else begin
                    d      = d - 4'd1;
                    borrow = 1'b0;
                end
            end
            r[i*4 +: 4] = d;
        end
        return r;
    endfunction

    // two flops per key against metastability
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= key;
            sync_2 <= sync_1;
        end
    end

    // the counter runs only while the synchronized key disagrees with the accepted level
    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
            for (int i = 0; i < n_keys; i++) begin
                stab_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < n_keys; i++) begin
                if (sync_2[i] == level[i]) begin
                    stab_cnt[i] <= '0;
                end else if (stab_cnt[i] == deb_w'(deb_len - 1)) begin
                    level[i]    <= sync_2[i];
                    stab_cnt[i] <= '0;
                end else begin
                    stab_cnt[i] <= stab_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign press = level & ~level_d;

    // key 2 clears, key 0 counts up, key 1 counts down, in that priority
    always_ff @(posedge clk) begin
        if (rst) begin
            level_d   <= '0;
            key_count <= '0;
        end else begin
            level_d <= level;
            if (press[2]) begin
                key_count <= '0;
            end else if (press[0]) begin
                key_count <= bcd_inc(key_count);
            end else if (press[1]) begin
                key_count <= bcd_dec(key_count);
            end
        end
    end

    assign key_level = level;

endmodule

`default_nettype wire

/* src/elapsed_time_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module elapsed_time_counter (
    input  logic             clk,
    input  logic             rst,
    input  logic             second_tick,
    output board_pkg::bcd4_t time_mmss,
    output logic             heartbeat
);

    import board_pkg::*;

    bcd_digit_t min_tens;
    bcd_digit_t min_units;
    bcd_digit_t sec_tens;
    bcd_digit_t sec_units;

    // units digits stop at 9, tens digits at 5
    always_ff @(posedge clk) begin
        if (rst) begin
            min_tens  <= '0;
            min_units <= '0;
            sec_tens  <= '0;
            sec_units <= '0;
            heartbeat <= 1'b0;
        end else if (second_tick) begin
            heartbeat <= ~heartbeat;
            if (sec_units == 4'd9) begin
                sec_units <= '0;
                if (sec_tens == 4'd5) begin
                    sec_tens <= '0;
                    if (min_units == 4'd9) begin
                        min_units <= '0;
                        // 59:59 goes back to 00:00
                        if (min_tens == 4'd5) begin
                            min_tens <= '0;
                        end else begin
                            min_tens <= min_tens + 4'd1;
                        end
                    end else begin
                        min_units <= min_units + 4'd1;
                    end
                end else begin
                    sec_tens <= sec_tens + 4'd1;
                end
            end else begin
                sec_units <= sec_units + 4'd1;
            end
        end
    end

    assign time_mmss = {min_tens, min_units, sec_tens, sec_units};

endmodule

`default_nettype wire

/* src/display_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module display_scanner #(
    parameter int clk_hz = 50_000_000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  board_pkg::bcd4_t      key_count,
    input  board_pkg::bcd4_t      time_mmss,
    input  board_pkg::key_vec_t   key_level,
    input  logic                  heartbeat,
    output board_pkg::disp_out_t  disp,
    output board_pkg::led_vec_t   led
);

    import board_pkg::*;

    localparam int scan_raw = clk_hz / scan_hz;
    localparam int scan_len = (scan_raw < 1) ? 1 : scan_raw;
    localparam int scan_w   = (scan_len > 1) ? $clog2(scan_len) : 1;
    localparam int idx_w    = $clog2(n_digits);

    logic [scan_w - 1:0]       scan_cnt;
    logic                      scan_step;
    logic [idx_w - 1:0]        idx;
    logic [4*n_digits - 1:0]   all_digits;
    bcd_digit_t                cur_digit;
    seg_t                      seg_next;
    digit_sel_t                sel_next;

    // standard seven-segment patterns, anything above 9 stays dark
    function automatic seg_t decode(input bcd_digit_t d);
        seg_t s;
        case (d)
            4'd0:    s = 8'b1111_1100;
            4'd1:    s = 8'b0110_0000;
            4'd2:    s = 8'b1101_1010;
            4'd3:    s = 8'b1111_0010;
            4'd4:    s = 8'b0110_0110;
            4'd5:    s = 8'b1011_0110;
            4'd6:    s = 8'b1011_1110;
            4'd7:    s = 8'b1110_0000;
            4'd8:    s = 8'b1111_1110;
            4'd9:    s = 8'b1111_0110;
            default: s = 8'b0000_0000;
        endcase
        return s;
    endfunction

    // with a one-cycle scan period the step is high every cycle
    assign scan_step = (scan_cnt == scan_w'(scan_len - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            idx      <= '0;
        end else if (scan_step) begin
            scan_cnt <= '0;
            if (idx == idx_w'(n_digits - 1)) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // the key count fills the left half, the time the right half
    assign all_digits = {key_count, time_mmss};
    assign cur_digit  = all_digits[(n_digits - 1 - idx) * 4 +: 4];

    always_comb begin
        seg_next = decode(cur_digit);
        if (idx == idx_w'(dot_index)) begin
            seg_next[0] = 1'b1;
        end
        sel_next = digit_sel_t'(1) << idx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp.seg <= '0;
            disp.sel <= digit_sel_t'(1);
        end else begin
            disp.seg <= seg_next;
            disp.sel <= sel_next;
        end
    end

    // heartbeat on the top led, key levels below it
    assign led = {heartbeat, key_level};

endmodule

`default_nettype wire

/* src/lab_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lab_top #(
    parameter int clk_hz = 50_000_000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  board_pkg::key_vec_t  key,
    output board_pkg::disp_out_t disp,
    output board_pkg::led_vec_t  led
);

    import board_pkg::*;

    logic     second_tick;
    key_vec_t key_level;
    bcd4_t    key_count;
    bcd4_t    time_mmss;
    logic     heartbeat;

    second_tick_gen #(
        .clk_hz (clk_hz)
    ) second_tick_gen_inst (
        .clk         (clk),
        .rst         (rst),
        .second_tick (second_tick)
    );

    key_press_counter #(
        .clk_hz (clk_hz)
    ) key_press_counter_inst (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .key_level (key_level),
        .key_count (key_count)
    );

    elapsed_time_counter elapsed_time_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .second_tick (second_tick),
        .time_mmss   (time_mmss),
        .heartbeat   (heartbeat)
    );

    // both counts meet here on one eight-digit display
    display_scanner #(
        .clk_hz (clk_hz)
    ) display_scanner_inst (
        .clk       (clk),
        .rst       (rst),
        .key_count (key_count),
        .time_mmss (time_mmss),
        .key_level (key_level),
        .heartbeat (heartbeat),
        .disp      (disp),
        .led       (led)
    );

endmodule

`default_nettype wire

/* src/board_specific_top.sv */
`timescale 1ns/100ps
`default_nettype none

module board_specific_top #(
    parameter int clk_hz = 50_000_000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  board_pkg::key_vec_t   key_n,
    output board_pkg::led_vec_t   led,
    output board_pkg::seg_t       seg_data,
    output board_pkg::digit_sel_t seg_sel
);

    import board_pkg::*;

    logic      rst;
    key_vec_t  key;
    disp_out_t disp;

    // the reset button and the push keys pull low when pressed
    assign rst = ~rst_n;
    assign key = ~key_n;

    lab_top #(
        .clk_hz (clk_hz)
    ) lab_top_inst (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .disp (disp),
        .led  (led)
    );

    // common-anode display, so a lit segment and a selected digit are both driven low
    assign seg_data = ~disp.seg;
    assign seg_sel  = ~disp.sel;

endmodule

`default_nettype wire

/* verification/tb_board_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int clk_hz     = 8;
    localparam int tick_len   = 8;
    localparam int max_cycles = tick_len * 5000;

    logic       clk;
    logic       rst_n;
    key_vec_t   key_n;
    led_vec_t   led;
    seg_t       seg_data;
    digit_sel_t seg_sel;

    int         cycle_count;
    int         run_cycles;
    int         errors;
    int         checks;
    int         scans;
    int         model_count;

    // what the monitor last saw on each digit, with the cycle it was seen in
    logic [3:0] shadow     [n_digits];
    logic       shadow_dot [n_digits];
    int         stamp      [n_digits];

    board_specific_top #(
        .clk_hz (clk_hz)
    ) board_specific_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_n    (key_n),
        .led      (led),
        .seg_data (seg_data),
        .seg_sel  (seg_sel)
    );

    always #20 clk = ~clk;

    // counts rising edges since reset was released
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= max_cycles) begin
            $display("timeout: the run did not end within %0d cycles", max_cycles);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("tests failed");
            $finish;
        end
    end

    function automatic int onehot_index(input logic [7:0] sel);
        int pos;
        pos = -1;
        if ($countones(sel) == 1) begin
            for (int i = 0; i < n_digits; i++) begin
                if (sel[i]) begin
                    pos = i;
                end
            end
        end
        return pos;
    endfunction

    // turns the segments a to g back into the decimal digit they show
    function automatic int seg_to_digit(input logic [6:0] abcdefg);
        case (abcdefg)
            7'b1111110: return 0;
            7'b0110000: return 1;
            7'b1101101: return 2;
            7'b1111001: return 3;
            7'b0110011: return 4;
            7'b1011011: return 5;
            7'b1011111: return 6;
            7'b1110000: return 7;
            7'b1111111: return 8;
            7'b1111011: return 9;
            default:    return -1;
        endcase
    endfunction

    function automatic int mmss_of(input int ticks);
        int t;
        t = ticks % 3600;
        return (t / 60) * 100 + t % 60;
    endfunction

    function automatic int shadow_value(input int base);
        return shadow[base] * 1000 + shadow[base + 1] * 100
             + shadow[base + 2] * 10 + shadow[base + 3];
    endfunction

    // the pins are active low, so undo that before decoding
    always @(negedge clk) begin
        logic [7:0] seg;
        logic [7:0] sel;
        int         pos;
        int         digit;
        if (rst_n && cycle_count > 0) begin
            seg   = ~seg_data;
            sel   = ~seg_sel;
            pos   = onehot_index(sel);
            digit = seg_to_digit(seg[7:1]);
            assert (pos >= 0) else begin
                errors++;
                $display("error at %0t: digit select %b is not one-hot", $time, sel);
            end
            assert (digit >= 0) else begin
                errors++;
                $display("error at %0t: segment pattern %b is not a decimal digit", $time, seg);
            end
            if (pos >= 0) begin
                shadow[pos]     = (digit >= 0) ? digit[3:0] : 4'hf;
                shadow_dot[pos] = seg[0];
                stamp[pos]      = cycle_count;
                if (pos == n_digits - 1) begin
                    scans++;
                end
            end
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic wait_until_cycle(input int target);
        while (cycle_count < target) begin
            @(negedge clk);
        end
    endtask

    // two index 7 captures guarantee one complete fresh scan
    task automatic wait_full_scan();
        int s;
        s = scans;
        while (scans < s + 2) begin
            @(posedge clk);
        end
    endtask

    task automatic press_key(input int k);
        @(posedge clk);
        key_n[k] <= 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value($sformatf("led[2:0] while key %0d held", k), 1 << k, led[2:0]);
        @(posedge clk);
        key_n[k] <= 1'b1;
        repeat (6) @(posedge clk);
        case (k)
            0: model_count = (model_count + 1) % 10000;
            1: model_count = (model_count + 9999) % 10000;
            default: model_count = 0;
        endcase
    endtask

    // a one-cycle glitch is shorter than the debounce length
    task automatic bounce_key(input int k);
        @(posedge clk);
        key_n[k] <= 1'b0;
        @(posedge clk);
        key_n[k] <= 1'b1;
        repeat (6) @(posedge clk);
    endtask

    task automatic check_key_count();
        repeat (4) @(posedge clk);
        wait_full_scan();
        check_value("key_count digits", model_count, shadow_value(0));
    endtask

    // the group of digits 4 to 7 is captured in four consecutive cycles
    task automatic check_time_display(input int n);
        int s;
        int ticks;
        wait_until_cycle(tick_len * n + 1);
        s = scans;
        while (scans <= s) begin
            @(posedge clk);
        end
        ticks = (stamp[4] - 2) / tick_len;
        check_value($sformatf("time_mmss digits near tick %0d", n), mmss_of(ticks),
                    shadow_value(4));
    endtask

    task automatic check_heartbeat();
        @(negedge clk);
        while (cycle_count % tick_len != 4) begin
            @(negedge clk);
        end
        check_value("led[3]", ((cycle_count - 1) / tick_len) % 2, led[3]);
    endtask

    task automatic test_reset();
        wait_until_cycle(4);
        check_value("led", 0, led);
        wait (scans >= 1);
        @(posedge clk);
        for (int i = 0; i < n_digits; i++) begin
            check_value($sformatf("digit %0d", i), 0, shadow[i]);
            check_value($sformatf("dot %0d", i), (i == 5) ? 1 : 0, shadow_dot[i]);
        end
    endtask

    task automatic test_key_counting();
        for (int i = 0; i < 12; i++) begin
            press_key(0);
        end
        check_key_count();
        for (int i = 0; i < 3; i++) begin
            press_key(1);
        end
        check_key_count();
    endtask

    task automatic test_wrap_and_clear();
        press_key(2);
        press_key(1);
        check_key_count();
        press_key(0);
        check_key_count();
        for (int i = 0; i < 3; i++) begin
            press_key(0);
        end
        check_key_count();
        press_key(2);
        check_key_count();
        bounce_key(0);
        check_key_count();
    endtask

    task automatic test_elapsed_time();
        check_time_display(59);
        check_time_display(60);
        check_heartbeat();
        check_time_display(119);
        check_time_display(120);
        check_heartbeat();
        check_time_display(200);
        check_heartbeat();
    endtask

    task automatic test_time_wrap();
        check_time_display(3599);
        check_time_display(3600);
        check_time_display(3601);
        check_heartbeat();
        check_key_count();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        key_n       = '1;
        run_cycles  = 0;
        errors      = 0;
        checks      = 0;
        scans       = 0;
        model_count = 0;
        for (int i = 0; i < n_digits; i++) begin
            shadow[i]     = 4'hf;
            shadow_dot[i] = 1'b0;
            stamp[i]      = 0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_key_counting();
        test_wrap_and_clear();
        test_elapsed_time();
        test_time_wrap();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/board_pkg.sv
src/second_tick_gen.sv
src/key_press_counter.sv
src/elapsed_time_counter.sv
src/display_scanner.sv
src/lab_top.sv
src/board_specific_top.sv
verification/tb_board_top.sv
